// File: project.f
mdu_pkg.sv
mdu_issue_if.sv
mdu_iq_entry.sv
mdu_issue_queue.sv
mdu_unit.sv
mdu_subsystem.sv
mdu_subsystem_assertions.sv
tb_mdu_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mdu_subsystem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "test did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_mdu_subsystem.sv
`default_nettype none
`timescale 1ns/10ps

module tb_mdu_subsystem;
    import mdu_pkg::*;

    // dispatch edge, issue register load, issue edge, then two multiply stages
    localparam int MUL_LATENCY = 5;
    localparam int WAIT_LIMIT  = 2000;

    logic             clk;
    logic             reset_i;
    logic             flush_i;
    logic [1:0]       dispatch_valid;
    mdu_slot_t [1:0]  dispatch_slot;
    logic             dispatch_ready;
    logic             cdb_valid;
    rob_tag_t         cdb_tag;
    word_t            cdb_data;
    logic             result_valid;
    logic             result_ready;
    word_t            result_data;
    rob_tag_t         result_tag;

    int               error_count;
    int               check_count;
    rob_tag_t         next_tag;
    word_t            exp_data [$];
    rob_tag_t         exp_tag [$];
    string            exp_name [$];

    mdu_subsystem u_dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_slot_i  (dispatch_slot),
        .dispatch_ready_o (dispatch_ready),
        .cdb_valid_i      (cdb_valid),
        .cdb_tag_i        (cdb_tag),
        .cdb_data_i       (cdb_data),
        .result_valid_o   (result_valid),
        .result_ready_i   (result_ready),
        .result_data_o    (result_data),
        .result_tag_o     (result_tag)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // reference model and helpers
    // ----------------------------------------
    function automatic word_t ref_model(mdu_op_e op, word_t a, word_t b);
        logic signed [63:0] sp;
        logic [63:0]        up;
        logic               ovf;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        sp  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up  = {32'b0, a} * {32'b0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        // signed quotient and remainder only where the division is defined
        sq  = '0;
        sr  = '0;
        if (b != 0 && !ovf) begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (op)
            MDU_MUL:   return up[31:0];
            MDU_MULH:  return sp[63:32];
            MDU_MULHU: return up[63:32];
            MDU_DIV:   return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
            MDU_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            MDU_REM:   return (b == 0) ? a : (ovf ? 32'h0 : sr);
            MDU_REMU:  return (b == 0) ? a : a % b;
            default:   return 32'h0;
        endcase
    endfunction

    function automatic mdu_slot_t make_slot(mdu_op_e op, rob_tag_t dst, word_t a, word_t b);
        mdu_slot_t s;
        s.op      = op;
        s.dst_tag = dst;
        s.src_a   = '{valid: 1'b1, tag: 5'd0, data: a};
        s.src_b   = '{valid: 1'b1, tag: 5'd0, data: b};
        return s;
    endfunction

    task automatic expect_result(string name, mdu_op_e op, word_t a, word_t b, rob_tag_t tag);
        exp_name.push_back(name);
        exp_data.push_back(ref_model(op, a, b));
        exp_tag.push_back(tag);
    endtask

    // waits for dispatch_ready, then holds the slots for one cycle
    task automatic send(mdu_slot_t s0, mdu_slot_t s1, logic [1:0] valid);
        int t;
        t = 0;
        @(negedge clk);
        while (!dispatch_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            $display("timeout: dispatch_ready never rose");
            error_count++;
        end
        dispatch_slot  = {s1, s0};
        dispatch_valid = valid;
        @(negedge clk);
        dispatch_valid = 2'b00;
    endtask

    task automatic run_op(string name, mdu_op_e op, word_t a, word_t b);
        rob_tag_t tag;
        tag = next_tag;
        next_tag++;
        expect_result(name, op, a, b, tag);
        send(make_slot(op, tag, a, b), '0, 2'b01);
    endtask

    task automatic run_pair(string name, mdu_op_e op0, mdu_op_e op1);
        word_t    a0;
        word_t    b0;
        word_t    a1;
        word_t    b1;
        rob_tag_t t0;
        rob_tag_t t1;
        a0 = $urandom();
        b0 = $urandom();
        a1 = $urandom();
        b1 = $urandom();
        t0 = next_tag;
        next_tag++;
        t1 = next_tag;
        next_tag++;
        expect_result(name, op0, a0, b0, t0);
        expect_result(name, op1, a1, b1, t1);
        send(make_slot(op0, t0, a0, b0), make_slot(op1, t1, a1, b1), 2'b11);
    endtask

    task automatic broadcast(rob_tag_t tag, word_t data);
        @(negedge clk);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_data  = data;
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic drain(string name);
        int t;
        t = 0;
        while (exp_data.size() != 0 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            $display("timeout in %s: %0d results never arrived", name, exp_data.size());
            error_count++;
        end
    endtask

    task automatic expect_quiet(string name, int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_count++;
            assert (!result_valid) else begin
                $display("%s: result appeared before its operands or after a flush", name);
                error_count++;
            end
        end
    endtask

    // results are compared in order at the transfer edge
    always @(posedge clk) begin
        if (!reset_i && result_valid && result_ready) begin
            check_count++;
            if (exp_data.size() == 0) begin
                $display("unexpected result with tag %0d and data %h", result_tag, result_data);
                error_count++;
            end else begin
                assert (result_data == exp_data[0] && result_tag == exp_tag[0]) else begin
                    $display("mismatch %s: expected %h tag %0d, actual %h tag %0d",
                             exp_name[0], exp_data[0], exp_tag[0], result_data, result_tag);
                    error_count++;
                end
                void'(exp_data.pop_front());
                void'(exp_tag.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_multiply();
        mdu_op_e ops [4];
        int      cycles;
        ops = '{MDU_MUL, MDU_MULH, MDU_MULHU, MDU_MUL};
        // uncontended latency
        run_op("multiply", MDU_MULH, 32'hdead_beef, 32'h1234_5678);
        cycles = 1;
        while (!result_valid && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        check_count++;
        assert (cycles == MUL_LATENCY) else begin
            $display("mismatch multiply latency: expected %0d, actual %0d", MUL_LATENCY, cycles);
            error_count++;
        end
        for (int i = 0; i < 12; i++) begin
            run_op("multiply", ops[i % 4], $urandom(), $urandom());
        end
        for (int i = 0; i < 8; i++) begin
            run_pair("multiply", ops[i % 4], ops[(i + 1) % 4]);
        end
        drain("multiply");
    endtask

    task automatic test_divide();
        mdu_op_e ops [4];
        word_t   va [6];
        word_t   vb [6];
        ops = '{MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU};
        va  = '{32'd7, 32'hffff_fff9, 32'h1234_5678, 32'h8000_0000, 32'h0, 32'hffff_ffff};
        vb  = '{32'd2, 32'd2, 32'h0, 32'hffff_ffff, 32'h5, 32'h8000_0000};
        foreach (ops[i]) begin
            foreach (va[j]) begin
                run_op("divide edge", ops[i], va[j], vb[j]);
            end
            run_op("divide random", ops[i], $urandom(), $urandom());
            run_op("divide small", ops[i], $urandom(), $urandom() % 300);
        end
        run_pair("divide pair", MDU_DIV, MDU_REMU);
        drain("divide");
    endtask

    task automatic test_wakeup();
        mdu_slot_t s;
        rob_tag_t  tag;
        tag = next_tag;
        next_tag++;
        s = make_slot(MDU_MUL, tag, 32'h0, 32'd3);
        s.src_a = '{valid: 1'b0, tag: 5'd21, data: 32'h0};
        expect_result("wakeup one", MDU_MUL, 32'd1234, 32'd3, tag);
        send(s, '0, 2'b01);
        expect_quiet("wakeup one", 6);
        broadcast(5'd21, 32'd1234);
        drain("wakeup one");

        tag = next_tag;
        next_tag++;
        s = make_slot(MDU_DIVU, tag, 32'h0, 32'h0);
        s.src_a = '{valid: 1'b0, tag: 5'd22, data: 32'h0};
        s.src_b = '{valid: 1'b0, tag: 5'd23, data: 32'h0};
        expect_result("wakeup two", MDU_DIVU, 32'd1000, 32'd7, tag);
        send(s, '0, 2'b01);
        broadcast(5'd23, 32'd7);
        expect_quiet("wakeup two", 5);
        broadcast(5'd22, 32'd1000);
        drain("wakeup two");

        // broadcast lands on the dispatch edge
        tag = next_tag;
        next_tag++;
        s = make_slot(MDU_MULHU, tag, 32'hffff_0000, 32'h0);
        s.src_b = '{valid: 1'b0, tag: 5'd24, data: 32'h0};
        expect_result("wakeup same cycle", MDU_MULHU, 32'hffff_0000, 32'h8765_4321, tag);
        @(negedge clk);
        dispatch_slot  = {mdu_slot_t'('0), s};
        dispatch_valid = 2'b01;
        cdb_valid      = 1'b1;
        cdb_tag        = 5'd24;
        cdb_data       = 32'h8765_4321;
        @(negedge clk);
        dispatch_valid = 2'b00;
        cdb_valid      = 1'b0;
        drain("wakeup same cycle");
    endtask

    task automatic test_backpressure();
        int    lows;
        word_t held;
        lows = 0;
        result_ready = 1'b0;
        for (int i = 0; i < 40 && lows < 10; i++) begin
            @(negedge clk);
            if (dispatch_ready) begin
                run_pair("backpressure", MDU_MUL, MDU_MULHU);
            end else begin
                // a pair offered while the queue is full must be refused
                dispatch_valid = 2'b11;
                @(negedge clk);
                dispatch_valid = 2'b00;
                lows++;
            end
        end
        check_count++;
        assert (!dispatch_ready && result_valid) else begin
            $display("back-pressure did not stall dispatch");
            error_count++;
        end
        held = result_data;
        repeat (6) @(negedge clk);
        check_count++;
        assert (result_data == held) else begin
            $display("mismatch backpressure hold: expected %h, actual %h", held, result_data);
            error_count++;
        end
        result_ready = 1'b1;
        drain("backpressure");
    endtask

    task automatic test_flush();
        send(make_slot(MDU_DIV, 5'd30, 32'd99, 32'd4), make_slot(MDU_MUL, 5'd31, 32'd5, 32'd6),
             2'b11);
        send(make_slot(MDU_MUL, 5'd29, 32'd8, 32'd9), '0, 2'b01);
        repeat (8) @(negedge clk);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        check_count++;
        assert (dispatch_ready) else begin
            $display("dispatch_ready is low after a flush");
            error_count++;
        end
        expect_quiet("flush", 50);
        run_op("after flush", MDU_MUL, $urandom(), $urandom());
        drain("after flush");
    endtask

    initial begin
        void'($urandom(32'h1ea6));
        clk            = 1'b0;
        reset_i        = 1'b1;
        flush_i        = 1'b0;
        dispatch_valid = 2'b00;
        dispatch_slot  = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_data       = '0;
        result_ready   = 1'b1;
        error_count    = 0;
        check_count    = 0;
        next_tag       = '0;
        repeat (4) @(negedge clk);
        reset_i = 1'b0;

        test_multiply();
        test_divide();
        test_wakeup();
        test_backpressure();
        test_flush();

        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mdu_subsystem_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module mdu_subsystem_assertions #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              flush_i,
    input  logic                              dispatch_ready_o,
    input  logic                              result_valid_o,
    input  logic                              result_ready_i,
    input  mdu_pkg::word_t                    result_data_o,
    input  mdu_pkg::rob_tag_t                 result_tag_o,
    input  logic                              issue_valid,
    input  logic                              issue_ready,
    input  logic [$clog2(IQ_DEPTH+1)-1:0]     free_count
);

    // ----------------------------------------
    // handshake rules
    // ----------------------------------------
    held_result: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        result_valid_o && !result_ready_i |=>
            result_valid_o && $stable(result_data_o) && $stable(result_tag_o))
        else $error("result changed under back-pressure");

    issue_hold: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        issue_valid && !issue_ready |=> issue_valid)
        else $error("issue valid dropped before ready");

    // queue only fills on accepted dispatch
    no_dispatch: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        !dispatch_ready_o |=> free_count >= $past(free_count))
        else $error("dispatch accepted while ready was low");

    reset_quiet: assert property (@(posedge clk) reset_i |=> !result_valid_o)
        else $error("result valid after reset");

endmodule

bind mdu_subsystem mdu_subsystem_assertions #(
    .IQ_DEPTH (IQ_DEPTH)
) u_assertions (
    .clk              (clk),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .dispatch_ready_o (dispatch_ready_o),
    .result_valid_o   (result_valid_o),
    .result_ready_i   (result_ready_i),
    .result_data_o    (result_data_o),
    .result_tag_o     (result_tag_o),
    .issue_valid      (u_issue_if.valid),
    .issue_ready      (u_issue_if.ready),
    .free_count       (u_queue.free_q)
);

`default_nettype wire

// File: mdu_subsystem.sv
`default_nettype none
`timescale 1ns/10ps

module mdu_subsystem #(
    parameter int IQ_DEPTH = mdu_pkg::MDU_IQ_DEPTH_DEF
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    // dispatch, slot 0 is older
    input  logic [1:0]               dispatch_valid_i,
    input  mdu_pkg::mdu_slot_t [1:0] dispatch_slot_i,
    output logic                     dispatch_ready_o,
    // common data bus
    input  logic                     cdb_valid_i,
    input  mdu_pkg::rob_tag_t        cdb_tag_i,
    input  mdu_pkg::word_t           cdb_data_i,
    // result toward downstream FIFO
    output logic                     result_valid_o,
    input  logic                     result_ready_i,
    output mdu_pkg::word_t           result_data_o,
    output mdu_pkg::rob_tag_t        result_tag_o
);

    mdu_issue_if u_issue_if ();

    mdu_issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_queue (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_slot_i  (dispatch_slot_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_tag_i        (cdb_tag_i),
        .cdb_data_i       (cdb_data_i),
        .issue            (u_issue_if.queue_side)
    );

    mdu_unit u_unit (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .issue          (u_issue_if.unit_side),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_data_o  (result_data_o),
        .result_tag_o   (result_tag_o)
    );

endmodule

`default_nettype wire

// File: mdu_unit.sv
`default_nettype none
`timescale 1ns/10ps

module mdu_unit (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              flush_i,
    mdu_issue_if.unit_side    issue,
    output logic              result_valid_o,
    input  logic              result_ready_i,
    output mdu_pkg::word_t    result_data_o,
    output mdu_pkg::rob_tag_t result_tag_o
);
    import mdu_pkg::*;

    localparam int CNT_W = $clog2(MDU_DIV_STEPS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIV,
        ST_DONE
    } div_state_e;

    div_state_e         state_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               res_free;
    logic               issue_fire;
    logic               issue_is_div;
    logic               div_emit;
    logic               signed_div;
    logic               a_neg;
    logic               b_neg;
    // multiply pipeline
    logic               m1_valid_q;
    mdu_op_e            m1_op_q;
    rob_tag_t           m1_tag_q;
    logic signed [32:0] m1_a_q;
    logic signed [32:0] m1_b_q;
    logic signed [65:0] mul_full;
    logic               p2_valid_q;
    mdu_op_e            p2_op_q;
    rob_tag_t           p2_tag_q;
    logic [63:0]        p2_prod_q;
    // divider datapath
    mdu_op_e            div_op_q;
    rob_tag_t           div_tag_q;
    logic               div_neg_q_q;
    logic               div_neg_r_q;
    logic               div_zero_q;
    word_t              divisor_q;
    word_t              rem_q;
    word_t              quo_q;
    logic [32:0]        div_shift;
    logic [32:0]        div_diff;
    logic               div_take;
    word_t              div_quo_fix;
    word_t              div_rem_fix;
    // result register
    logic               res_valid_q;
    word_t              res_data_q;
    rob_tag_t           res_tag_q;

    // ----------------------------------------
    // issue handshake
    // ----------------------------------------
    assign res_free     = !res_valid_q || result_ready_i;
    assign issue.ready  = res_free && state_q == ST_IDLE;
    assign issue_fire   = issue.valid && issue.ready;
    assign issue_is_div = issue.op inside {MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU};

    // older multiplies leave the pipe before a divide result
    assign div_emit = state_q == ST_DONE && res_free && !m1_valid_q && !p2_valid_q;

    // ----------------------------------------
    // multiplier, stalls as one block
    // ----------------------------------------
    // MULH sign-extends, MUL low half is the same either way
    assign mul_full = m1_a_q * m1_b_q;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            m1_valid_q  <= 1'b0;
            p2_valid_q  <= 1'b0;
            res_valid_q <= 1'b0;
        end else if (res_free) begin
            m1_valid_q  <= issue_fire && !issue_is_div;
            p2_valid_q  <= m1_valid_q;
            res_valid_q <= p2_valid_q || div_emit;
        end
    end

    always_ff @(posedge clk) begin
        if (res_free) begin
            m1_op_q   <= issue.op;
            m1_tag_q  <= issue.dst_tag;
            m1_a_q    <= {issue.op == MDU_MULH && issue.src_a[31], issue.src_a};
            m1_b_q    <= {issue.op == MDU_MULH && issue.src_b[31], issue.src_b};
            p2_op_q   <= m1_op_q;
            p2_tag_q  <= m1_tag_q;
            p2_prod_q <= mul_full[63:0];
            if (p2_valid_q) begin
                res_data_q <= (p2_op_q == MDU_MUL) ? p2_prod_q[31:0] : p2_prod_q[63:32];
                res_tag_q  <= p2_tag_q;
            end else if (div_emit) begin
                res_data_q <= (div_op_q inside {MDU_REM, MDU_REMU}) ? div_rem_fix : div_quo_fix;
                res_tag_q  <= div_tag_q;
            end
        end
    end

    // ----------------------------------------
    // restoring divider on magnitudes
    // ----------------------------------------
    assign signed_div = issue.op == MDU_DIV || issue.op == MDU_REM;
    assign a_neg      = signed_div && issue.src_a[31];
    assign b_neg      = signed_div && issue.src_b[31];

    assign div_shift = {rem_q, quo_q[31]};
    assign div_diff  = div_shift - {1'b0, divisor_q};
    assign div_take  = div_shift >= {1'b0, divisor_q};

    // by zero every trial passes, so quotient is forced and remainder is the dividend
    // most negative by -1 already lands on dividend and zero
    assign div_quo_fix = div_zero_q ? '1 : (div_neg_q_q ? -quo_q : quo_q);
    assign div_rem_fix = div_neg_r_q ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (issue_fire && issue_is_div) begin
                        state_q <= ST_DIV;
                        cnt_q   <= '0;
                    end
                end
                ST_DIV: begin
                    cnt_q <= cnt_q + CNT_W'(1);
                    if (cnt_q == CNT_W'(MDU_DIV_STEPS - 1)) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (div_emit) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire && issue_is_div) begin
            div_op_q    <= issue.op;
            div_tag_q   <= issue.dst_tag;
            div_neg_q_q <= a_neg ^ b_neg;
            div_neg_r_q <= a_neg;
            div_zero_q  <= issue.src_b == '0;
            divisor_q   <= b_neg ? -issue.src_b : issue.src_b;
            quo_q       <= a_neg ? -issue.src_a : issue.src_a;
            rem_q       <= '0;
        end else if (state_q == ST_DIV) begin
            rem_q <= div_take ? div_diff[31:0] : div_shift[31:0];
            quo_q <= {quo_q[30:0], div_take};
        end
    end

    assign result_valid_o = res_valid_q;
    assign result_data_o  = res_data_q;
    assign result_tag_o   = res_tag_q;

endmodule

`default_nettype wire

// File: mdu_issue_queue.sv
`default_nettype none
`timescale 1ns/10ps

module mdu_issue_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  logic [1:0]               dispatch_valid_i,
    input  mdu_pkg::mdu_slot_t [1:0] dispatch_slot_i,
    output logic                     dispatch_ready_o,
    input  logic                     cdb_valid_i,
    input  mdu_pkg::rob_tag_t        cdb_tag_i,
    input  mdu_pkg::word_t           cdb_data_i,
    mdu_issue_if.queue_side          issue
);
    import mdu_pkg::*;

    localparam int PTR_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    logic [PTR_W-1:0]    head_q;
    logic [PTR_W-1:0]    tail_q;
    logic [PTR_W-1:0]    tail_second;
    logic [CNT_W-1:0]    free_q;
    logic [CNT_W-1:0]    free_d;
    logic [CNT_W-1:0]    accept_cnt;
    logic [1:0]          accept;
    logic                accept_both;
    mdu_slot_t           first_slot;
    logic [IQ_DEPTH-1:0] entry_init;
    logic [IQ_DEPTH-1:0] entry_clear;
    logic [IQ_DEPTH-1:0] entry_ready;
    mdu_slot_t           entry_slot_in [IQ_DEPTH];
    mdu_slot_t           entry_slot [IQ_DEPTH];
    logic                head_ready;
    logic                iss_load;
    logic                pop;
    logic                iss_valid_q;
    mdu_op_e             iss_op_q;
    word_t               iss_a_q;
    word_t               iss_b_q;
    rob_tag_t            iss_tag_q;

    // ----------------------------------------
    // dispatch steering
    // ----------------------------------------
    assign accept      = dispatch_valid_i & {2{dispatch_ready_o}};
    assign accept_both = &accept;
    assign accept_cnt  = CNT_W'(accept[0]) + CNT_W'(accept[1]);
    assign tail_second = tail_q + PTR_W'(1);
    // lone slot 1 goes to the tail like slot 0 would
    assign first_slot  = accept[0] ? dispatch_slot_i[0] : dispatch_slot_i[1];

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        assign entry_init[i] = ((|accept) && tail_q == PTR_W'(i))
                             || (accept_both && tail_second == PTR_W'(i));
        assign entry_slot_in[i] = (accept_both && tail_second == PTR_W'(i))
                                ? dispatch_slot_i[1] : first_slot;
        assign entry_clear[i] = pop && head_q == PTR_W'(i);

        mdu_iq_entry u_entry (
            .clk         (clk),
            .reset_i     (reset_i),
            .flush_i     (flush_i),
            .init_i      (entry_init[i]),
            .slot_i      (entry_slot_in[i]),
            .clear_i     (entry_clear[i]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .busy_o      (),
            .ready_o     (entry_ready[i]),
            .slot_o      (entry_slot[i])
        );
    end

    // ----------------------------------------
    // pointers and free count
    // ----------------------------------------
    assign free_d = free_q - accept_cnt + CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            free_q           <= CNT_W'(IQ_DEPTH);
            dispatch_ready_o <= 1'b1;
        end else begin
            head_q           <= head_q + PTR_W'(pop);
            tail_q           <= tail_q + PTR_W'(accept_cnt);
            free_q           <= free_d;
            // room for a full pair next cycle
            dispatch_ready_o <= free_d >= CNT_W'(2);
        end
    end

    // ----------------------------------------
    // in-order issue from the head
    // ----------------------------------------
    assign head_ready = entry_ready[head_q];
    assign iss_load   = !iss_valid_q || issue.ready;
    assign pop        = iss_load && head_ready;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            iss_valid_q <= 1'b0;
        end else if (iss_load) begin
            iss_valid_q <= head_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            iss_op_q  <= entry_slot[head_q].op;
            iss_a_q   <= entry_slot[head_q].src_a.data;
            iss_b_q   <= entry_slot[head_q].src_b.data;
            iss_tag_q <= entry_slot[head_q].dst_tag;
        end
    end

    assign issue.valid   = iss_valid_q;
    assign issue.op      = iss_op_q;
    assign issue.src_a   = iss_a_q;
    assign issue.src_b   = iss_b_q;
    assign issue.dst_tag = iss_tag_q;

endmodule

`default_nettype wire

// File: mdu_iq_entry.sv
`default_nettype none
`timescale 1ns/10ps

module mdu_iq_entry (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               init_i,
    input  mdu_pkg::mdu_slot_t slot_i,
    input  logic               clear_i,
    input  logic               cdb_valid_i,
    input  mdu_pkg::rob_tag_t  cdb_tag_i,
    input  mdu_pkg::word_t     cdb_data_i,
    output logic               busy_o,
    output logic               ready_o,
    output mdu_pkg::mdu_slot_t slot_o
);
    import mdu_pkg::*;

    logic      busy_q;
    mdu_slot_t slot_q;
    mdu_slot_t slot_d;

    // incoming slot or stored one, then cdb capture on top
    always_comb begin
        slot_d = init_i ? slot_i : slot_q;
        if (cdb_valid_i && !slot_d.src_a.valid && slot_d.src_a.tag == cdb_tag_i) begin
            slot_d.src_a.valid = 1'b1;
            slot_d.src_a.data  = cdb_data_i;
        end
        if (cdb_valid_i && !slot_d.src_b.valid && slot_d.src_b.tag == cdb_tag_i) begin
            slot_d.src_b.valid = 1'b1;
            slot_d.src_b.data  = cdb_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q <= 1'b0;
        end else if (init_i) begin
            busy_q <= 1'b1;
        end else if (clear_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (init_i || busy_q) begin
            slot_q <= slot_d;
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q && slot_q.src_a.valid && slot_q.src_b.valid;
    assign slot_o  = slot_q;

endmodule

`default_nettype wire

// File: mdu_issue_if.sv
`default_nettype none
`timescale 1ns/10ps

interface mdu_issue_if;
    import mdu_pkg::*;

    logic     valid;
    logic     ready;
    mdu_op_e  op;
    word_t    src_a;
    word_t    src_b;
    rob_tag_t dst_tag;

    // issue register side
    modport queue_side (
        output valid, op, src_a, src_b, dst_tag,
        input  ready
    );

    // execution side
    modport unit_side (
        input  valid, op, src_a, src_b, dst_tag,
        output ready
    );

endinterface

`default_nettype wire

// File: mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // ----------------------------------------
    // basic data types
    // ----------------------------------------
    typedef logic [31:0] word_t;

    // rename tag, 32 in flight
    typedef logic [4:0] rob_tag_t;

    typedef enum logic [2:0] {
        MDU_MUL   = 3'd0,
        MDU_MULH  = 3'd1,
        MDU_MULHU = 3'd2,
        MDU_DIV   = 3'd3,
        MDU_DIVU  = 3'd4,
        MDU_REM   = 3'd5,
        MDU_REMU  = 3'd6
    } mdu_op_e;

    // ----------------------------------------
    // dispatch structures
    // ----------------------------------------
    // operand either carries data or waits on tag
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
    } mdu_src_t;

    typedef struct packed {
        mdu_op_e  op;
        rob_tag_t dst_tag;
        mdu_src_t src_a;
        mdu_src_t src_b;
    } mdu_slot_t;

    parameter int MDU_IQ_DEPTH_DEF = 8;
    // one quotient bit per iteration
    parameter int MDU_DIV_STEPS = 32;

endpackage

`default_nettype wire
